// ==== Makefile ====
# Verilator flow for the fetch front end testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f project.f --top-module fetch_tb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/Vfetch_tb | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// ==== include/fetch_defines.svh ====
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Byte address width of the fetch path
`define FETCH_ADDR_W 32

// Instruction word width, no compressed forms
`define FETCH_INSTR_W 32

// Default instruction memory size as log2 of the word count
`define FETCH_IMEM_DEPTH_LOG2 8

// MISC-MEM major opcode, used here to stop fetch
`define FETCH_OP_HALT 7'b0001111

`endif

// ==== project.f ====
+incdir+include
source/fetch_pkg.sv
source/instr_mem.sv
source/fetch_buffer.sv
source/fe_ctl.sv
source/fetch_top.sv
tb/fetch_properties.sv
tb/fetch_tb.sv

// ==== source/fe_ctl.sv ====
`timescale 1ns/100ps
`default_nettype none

module fe_ctl (
    input  logic                  clk,
    input  logic                  reset,

    // Request and response with the fetch buffer
    output fetch_pkg::t_fe_fb_req fe_fb_req,
    input  fetch_pkg::t_fb_fe_rsp fb_fe_rsp,

    // Redirect from the branch unit
    input  fetch_pkg::t_paddr     br_tgt,
    input  logic                  br_mispred,

    // Decode side
    output logic                  valid_fe1,
    output fetch_pkg::t_instr_pkt instr_fe1,
    input  logic                  stall
);
    import fetch_pkg::*;

    t_fsm_fe    state;
    t_fsm_fe    state_nxt;
    t_paddr     pc;
    t_paddr     pc_nxt;
    logic       halt;
    logic       halted;
    logic       req_valid;
    t_instr_pkt pkt_live;
    t_instr_pkt pkt_held;

    // Halt opcode seen on a live response
    assign halt = fb_fe_rsp.valid && (fb_fe_rsp.instr.opcode == RV_OP_MISC);

    // After a halt, redirects no longer restart fetch
    assign halted = (state == FE_DRAIN) || (state == FE_HALT);

    always_comb begin
        state_nxt = state;
        unique case (state)
            FE_IDLE:      state_nxt = FE_REQ_IC;
            FE_REQ_IC:    state_nxt = FE_PDG_IC;
            // No stall means the next request already left, so stay here
            FE_PDG_IC:    if (fb_fe_rsp.valid && stall) state_nxt = FE_PDG_STALL;
            FE_PDG_STALL: if (!stall) state_nxt = FE_PDG_IC;
            FE_DRAIN:     state_nxt = FE_HALT;
            FE_HALT:      state_nxt = FE_HALT;
            default:      state_nxt = FE_IDLE;
        endcase
        if (halt) begin
            state_nxt = FE_DRAIN;
        end
        // Redirect wins over anything from the wrong path
        if (br_mispred && !halted) begin
            state_nxt = FE_REQ_IC;
        end
    end

    // One request at a time, never in a redirect cycle
    assign req_valid = !br_mispred
                     && ((state == FE_REQ_IC)
                      || (state == FE_PDG_IC && fb_fe_rsp.valid && !stall && !halt)
                      || (state == FE_PDG_STALL && !stall));

    assign fe_fb_req = '{valid: req_valid, addr: pc, id: 2'b00};

    // PC follows the redirect target, else steps past each request
    always_comb begin
        if (br_mispred && !halted) begin
            pc_nxt = br_tgt;
        end else if (req_valid) begin
            pc_nxt = pc + t_paddr'(4);
        end else begin
            pc_nxt = pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FE_IDLE;
            pc    <= '0;
        end else begin
            state <= state_nxt;
            pc    <= pc_nxt;
        end
    end

    // Keep the response so a stalled packet stays put
    assign pkt_live = '{pc: fb_fe_rsp.pc, instr: fb_fe_rsp.instr};

    always_ff @(posedge clk) begin
        if (fb_fe_rsp.valid) begin
            pkt_held <= pkt_live;
        end
    end

    // Live response on arrival, captured copy while decode stalls
    always_comb begin
        valid_fe1 = ((state == FE_PDG_IC && fb_fe_rsp.valid) || (state == FE_PDG_STALL))
                    && !br_mispred && !halt;
        instr_fe1 = (state == FE_PDG_IC) ? pkt_live : pkt_held;
    end

endmodule

`default_nettype wire

// ==== source/fetch_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_buffer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              flush,

    // From the fetch controller
    input  fetch_pkg::t_fe_fb_req             req,

    // Instruction memory read port
    output logic                              mem_re,
    output logic [`FETCH_IMEM_DEPTH_LOG2-1:0] mem_addr,
    input  fetch_pkg::t_rv_instr              mem_rdata,

    // Back to the fetch controller
    output fetch_pkg::t_fb_fe_rsp             rsp
);
    import fetch_pkg::*;

    // Outstanding request, valid for the single pending cycle
    t_fe_fb_req pend;
    // Set when the pending request was flushed in its request cycle
    logic       pend_dead;

    // Byte address to word index
    assign mem_re   = req.valid;
    assign mem_addr = req.addr[`FETCH_IMEM_DEPTH_LOG2+1:2];

    always_ff @(posedge clk) begin
        if (reset) begin
            pend.valid <= 1'b0;
            pend_dead  <= 1'b0;
        end else begin
            pend.valid <= req.valid;
            pend_dead  <= req.valid && flush;
        end
        if (req.valid) begin
            pend.addr <= req.addr;
            pend.id   <= req.id;
        end
    end

    // Memory data lines up with the pending entry
    // A flush in the pending cycle also kills the response
    assign rsp = '{
        valid: pend.valid && !pend_dead && !flush,
        pc:    pend.addr,
        instr: mem_rdata
    };

endmodule

`default_nettype wire

// ==== source/fetch_pkg.sv ====
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

    // Fetch address
    typedef logic [`FETCH_ADDR_W-1:0] t_paddr;

    // Major opcodes of the base integer set
    typedef enum logic [6:0] {
        RV_OP_LOAD   = 7'b0000011,
        RV_OP_MISC   = `FETCH_OP_HALT,
        RV_OP_IMM    = 7'b0010011,
        RV_OP_AUIPC  = 7'b0010111,
        RV_OP_STORE  = 7'b0100011,
        RV_OP        = 7'b0110011,
        RV_OP_LUI    = 7'b0110111,
        RV_OP_BRANCH = 7'b1100011,
        RV_OP_JALR   = 7'b1100111,
        RV_OP_JAL    = 7'b1101111,
        RV_OP_SYSTEM = 7'b1110011
    } t_rv_opcode;

    // Upper fields are not decoded in fetch
    typedef struct packed {
        logic [`FETCH_INSTR_W-8:0] upper;
        t_rv_opcode                opcode;
    } t_rv_instr;

    // Controller to buffer
    typedef struct packed {
        logic       valid;
        t_paddr     addr;
        logic [1:0] id;
    } t_fe_fb_req;

    // Buffer to controller
    typedef struct packed {
        logic      valid;
        t_paddr    pc;
        t_rv_instr instr;
    } t_fb_fe_rsp;

    // Packet handed to decode
    typedef struct packed {
        t_paddr    pc;
        t_rv_instr instr;
    } t_instr_pkt;

    typedef enum logic [2:0] {
        FE_IDLE,
        FE_REQ_IC,
        FE_PDG_IC,
        FE_PDG_STALL,
        FE_DRAIN,
        FE_HALT
    } t_fsm_fe;

endpackage

`default_nettype wire

// ==== source/fetch_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_top (
    input  logic                              clk,
    input  logic                              reset,
    input  fetch_pkg::t_paddr                 br_tgt,
    input  logic                              br_mispred,
    input  logic                              stall,
    output logic                              valid_fe1,
    output fetch_pkg::t_instr_pkt             instr_fe1,

    // Memory load port, used while reset is held
    input  logic                              mem_we,
    input  logic [`FETCH_IMEM_DEPTH_LOG2-1:0] mem_waddr,
    input  fetch_pkg::t_rv_instr              mem_wdata
);
    import fetch_pkg::*;

    t_fe_fb_req                        fe_fb_req;
    t_fb_fe_rsp                        fb_fe_rsp;
    logic                              mem_re;
    logic [`FETCH_IMEM_DEPTH_LOG2-1:0] mem_raddr;
    t_rv_instr                         mem_rdata;

    fe_ctl i_fe_ctl (
        .clk        (clk),
        .reset      (reset),
        .fe_fb_req  (fe_fb_req),
        .fb_fe_rsp  (fb_fe_rsp),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred),
        .valid_fe1  (valid_fe1),
        .instr_fe1  (instr_fe1),
        .stall      (stall)
    );

    fetch_buffer i_fetch_buffer (
        .clk       (clk),
        .reset     (reset),
        .flush     (br_mispred),
        .req       (fe_fb_req),
        .mem_re    (mem_re),
        .mem_addr  (mem_raddr),
        .mem_rdata (mem_rdata),
        .rsp       (fb_fe_rsp)
    );

    instr_mem #(
        .DEPTH_LOG2 (`FETCH_IMEM_DEPTH_LOG2)
    ) i_instr_mem (
        .clk   (clk),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata),
        .we    (mem_we),
        .waddr (mem_waddr),
        .wdata (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== source/instr_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module instr_mem #(
    parameter int DEPTH_LOG2 = `FETCH_IMEM_DEPTH_LOG2
) (
    input  logic                  clk,

    // Read port, data one cycle after re
    input  logic                  re,
    input  logic [DEPTH_LOG2-1:0] raddr,
    output fetch_pkg::t_rv_instr  rdata,

    // Load port
    input  logic                  we,
    input  logic [DEPTH_LOG2-1:0] waddr,
    input  fetch_pkg::t_rv_instr  wdata
);
    import fetch_pkg::*;

    localparam int DEPTH = 1 << DEPTH_LOG2;

    t_rv_instr mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read register holds its value while re is low
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== tb/fetch_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_properties (
    input logic                  clk,
    input logic                  reset,
    input fetch_pkg::t_fsm_fe    state,
    input fetch_pkg::t_fe_fb_req fe_fb_req,
    input fetch_pkg::t_fb_fe_rsp fb_fe_rsp,
    input logic                  valid_fe1,
    input fetch_pkg::t_instr_pkt instr_fe1,
    input logic                  stall
);
    import fetch_pkg::*;

    // Only one request may be outstanding
    a_no_req_while_pending: assert property (
        @(posedge clk) disable iff (reset)
        fe_fb_req.valid |=> (fb_fe_rsp.valid || !fe_fb_req.valid)
    ) else $error("second fetch request issued before the response arrived");

    // Decode sees the same packet for as long as it stalls
    a_stall_stable: assert property (
        @(posedge clk) disable iff (reset)
        (valid_fe1 && stall) |=> $stable(instr_fe1)
    ) else $error("instr_fe1 changed while decode was stalled");

    // Halt is sticky and quiet even if a redirect shows up
    a_halt_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (state == FE_DRAIN || state == FE_HALT)
            |=> (state == FE_HALT && !valid_fe1 && !fe_fb_req.valid)
    ) else $error("fetch left the halt state or became active after a halt");

endmodule

bind fe_ctl fetch_properties i_fetch_properties (
    .clk       (clk),
    .reset     (reset),
    .state     (state),
    .fe_fb_req (fe_fb_req),
    .fb_fe_rsp (fb_fe_rsp),
    .valid_fe1 (valid_fe1),
    .instr_fe1 (instr_fe1),
    .stall     (stall)
);

`default_nettype wire

// ==== tb/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_tb;
    import fetch_pkg::*;

    localparam int AW        = `FETCH_IMEM_DEPTH_LOG2;
    localparam int DEPTH     = 1 << AW;
    localparam int N_PROG    = 19;
    localparam int N_REDIR   = 2;
    localparam int HALT_WAIT = 20;

    logic       clk;
    logic       reset;
    t_paddr     br_tgt;
    logic       br_mispred;
    logic       stall;
    logic       valid_fe1;
    t_instr_pkt instr_fe1;
    logic       mem_we;
    logic [AW-1:0] mem_waddr;
    t_rv_instr  mem_wdata;

    // Program image, expected delivery stream and redirect points
    t_paddr     prog_addr [N_PROG];
    t_rv_instr  prog_instr [N_PROG];
    t_instr_pkt exp_q [$];
    int         redir_after [N_REDIR];
    t_paddr     redir_tgt [N_REDIR];
    integer     seed;

    fetch_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .br_tgt     (br_tgt),
        .br_mispred (br_mispred),
        .stall      (stall),
        .valid_fe1  (valid_fe1),
        .instr_fe1  (instr_fe1),
        .mem_we     (mem_we),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Test FAILED");
            $fatal(1, "Stopping at the first error");
        end
    endtask

    task automatic put_prog(input int i, input t_paddr addr,
                            input logic [`FETCH_INSTR_W-8:0] upper, input t_rv_opcode op);
        prog_addr[i]         = addr;
        prog_instr[i].upper  = upper;
        prog_instr[i].opcode = op;
    endtask

    // Word at a memory index, program first, else the fill pattern
    function automatic t_rv_instr word_at(input int idx);
        t_rv_instr w;
        w.upper  = 25'(idx) * 25'h0013579 ^ 25'h15a5a5a;
        w.opcode = RV_OP_AUIPC;
        for (int i = 0; i < N_PROG; i++) begin
            if (prog_addr[i] == (t_paddr'(idx) << 2)) begin
                w = prog_instr[i];
            end
        end
        return w;
    endfunction

    task automatic load_tables();
        put_prog(0,  32'h00, 25'h0000513, RV_OP_IMM);
        put_prog(1,  32'h04, 25'h0c58633, RV_OP);
        put_prog(2,  32'h08, 25'h12345b7, RV_OP_LUI);
        put_prog(3,  32'h0c, 25'h0000617, RV_OP_AUIPC);
        put_prog(4,  32'h10, 25'h0052683, RV_OP_LOAD);
        put_prog(5,  32'h14, 25'h00d5223, RV_OP_STORE);
        put_prog(6,  32'h18, 25'h0150593, RV_OP_IMM);
        put_prog(7,  32'h1c, 25'h04b5063, RV_OP_BRANCH);
        put_prog(8,  32'h20, 25'h1f0006f, RV_OP_JAL);
        put_prog(9,  32'h40, 25'h0a70713, RV_OP_IMM);
        put_prog(10, 32'h44, 25'h0e707b3, RV_OP);
        put_prog(11, 32'h48, 25'h0072803, RV_OP_LOAD);
        put_prog(12, 32'h4c, 25'h0008067, RV_OP_JALR);
        put_prog(13, 32'h50, 25'h1bad0b3, RV_OP);
        put_prog(14, 32'h80, 25'h0ff0893, RV_OP_IMM);
        put_prog(15, 32'h84, 25'h0000073, RV_OP_SYSTEM);
        put_prog(16, 32'h88, 25'h01188b3, RV_OP);
        put_prog(17, 32'h8c, 25'h0ff000f, RV_OP_MISC);
        put_prog(18, 32'h90, 25'h0dead13, RV_OP_IMM);
        // Redirect after the branch and after the jalr
        redir_after[0] = 7;
        redir_tgt[0]   = 32'h40;
        redir_after[1] = 11;
        redir_tgt[1]   = 32'h80;
    endtask

    // Walk the program as fetch should see it, up to the halt
    task automatic build_expected();
        t_paddr     pc;
        t_rv_instr  w;
        t_instr_pkt p;
        int         r;
        pc = '0;
        r  = 0;
        exp_q.delete();
        for (int k = 0; k < 64; k++) begin
            w = word_at(int'(pc >> 2));
            if (w.opcode == RV_OP_MISC) begin
                break;
            end
            p.pc    = pc;
            p.instr = w;
            exp_q.push_back(p);
            if (r < N_REDIR && redir_after[r] == k) begin
                pc = redir_tgt[r];
                r++;
            end else begin
                pc = pc + 32'd4;
            end
        end
    endtask

    // Budget of 20 cycles per delivered instruction plus the halt check
    initial begin
        @(negedge reset);
        repeat (20 * exp_q.size() + HALT_WAIT) @(posedge clk);
        $display("Timeout: fetch did not deliver the expected instruction stream in time");
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        int         n_done;
        int         redir_idx;
        int         rnd;
        logic       xfer;
        logic       held_valid;
        t_instr_pkt held;

        reset      = 1'b1;
        br_tgt     = '0;
        br_mispred = 1'b0;
        stall      = 1'b0;
        mem_we     = 1'b0;
        mem_waddr  = '0;
        mem_wdata  = '0;
        seed       = 32'he5a8;
        n_done     = 0;
        redir_idx  = 0;
        held_valid = 1'b0;
        held       = '0;
        load_tables();
        build_expected();

        // Whole memory through the load port while reset is held
        for (int a = 0; a < DEPTH; a++) begin
            @(posedge clk);
            mem_we    <= 1'b1;
            mem_waddr <= AW'(a);
            mem_wdata <= word_at(a);
        end
        @(posedge clk);
        mem_we <= 1'b0;
        repeat (2) begin
            @(posedge clk);
            check_value("valid_fe1", 64'(valid_fe1), 64'd0);
        end
        reset <= 1'b0;

        while (n_done < exp_q.size()) begin
            @(posedge clk);
            // Sampled values belong to the cycle that just ended
            if (held_valid && !br_mispred) begin
                check_value("valid_fe1", 64'(valid_fe1), 64'd1);
                check_value("instr_fe1", 64'(instr_fe1), 64'(held));
            end
            xfer       = valid_fe1 && !stall;
            held_valid = valid_fe1 && stall;
            held       = instr_fe1;
            if (xfer) begin
                check_value("instr_fe1.pc", 64'(instr_fe1.pc), 64'(exp_q[n_done].pc));
                check_value("instr_fe1.instr", 64'(instr_fe1.instr),
                            64'(exp_q[n_done].instr));
                n_done++;
            end
            rnd = $random(seed);
            stall <= rnd[0];
            if (xfer && redir_idx < N_REDIR && redir_after[redir_idx] == n_done - 1) begin
                br_mispred <= 1'b1;
                br_tgt     <= redir_tgt[redir_idx];
                redir_idx++;
            end else begin
                br_mispred <= 1'b0;
            end
        end

        // Nothing may follow the halt
        repeat (HALT_WAIT) begin
            @(posedge clk);
            check_value("valid_fe1", 64'(valid_fe1), 64'd0);
            rnd = $random(seed);
            stall <= rnd[0];
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
